/* rtl/apu_pkg.sv */
// APU cluster shared types
package apu_pkg;

   localparam int NUM_CORES = 4;
   localparam int TAG_W     = $clog2(NUM_CORES);
   localparam int WORD_W    = 32;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [TAG_W-1:0]  core_id_t;

   // Unit kind selected by a core request
   typedef enum logic {
      APU_MULT = 1'b0,
      APU_DIV  = 1'b1
   } apu_type_e;

   typedef enum logic [1:0] {
      MUL_LO  = 2'd0,
      MUL_HSS = 2'd1,
      MUL_HUU = 2'd2
   } mult_op_e;

   typedef enum logic [1:0] {
      DIV_S = 2'd0,
      DIV_U = 2'd1,
      REM_S = 2'd2,
      REM_U = 2'd3
   } div_op_e;

   // Request as presented by a core, op is decoded per unit
   typedef struct packed {
      logic       req;
      apu_type_e  apu_type;
      logic [1:0] op;
      word_t      a;
      word_t      b;
   } core_req_t;

   typedef struct packed {
      logic  valid;
      word_t result;
   } core_rsp_t;

   typedef struct packed {
      mult_op_e op;
      word_t    a;
      word_t    b;
   } mult_cmd_t;

   typedef struct packed {
      div_op_e op;
      word_t   a;
      word_t   b;
   } div_cmd_t;

   typedef struct packed {
      logic     valid;
      core_id_t tag;
      word_t    result;
   } unit_rsp_t;

endpackage

/* rtl/apu_arbiter.sv */
// Round-robin tagging arbiter
`timescale 1ns/1ps

module apu_arbiter #(
   parameter type payload_t = apu_pkg::mult_cmd_t
) (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic [apu_pkg::NUM_CORES-1:0]  req_i,
   input  payload_t                       payload_i [apu_pkg::NUM_CORES],
   input  logic                           ready_i,
   output logic [apu_pkg::NUM_CORES-1:0]  ack_o,
   output logic                           issue_o,
   output payload_t                       payload_o,
   output apu_pkg::core_id_t              tag_o
);

   import apu_pkg::*;

   core_id_t ptr_q;
   core_id_t win;
   logic     found;

   //////////////////////////////
   // Winner search
   //////////////////////////////

   // First requester at or after the pointer, wrapping around
   always_comb begin
      int idx;
      found = 1'b0;
      win   = '0;
      for (int i = 0; i < NUM_CORES; i++) begin
         idx = (int'(ptr_q) + i) % NUM_CORES;
         if (!found && req_i[idx]) begin
            found = 1'b1;
            win   = core_id_t'(idx);
         end
      end
   end

   assign issue_o   = found && ready_i;
   assign payload_o = payload_i[win];
   assign tag_o     = win;

   // Ack only the granted core, in the issue cycle
   always_comb begin
      ack_o      = '0;
      ack_o[win] = issue_o;
   end

   //////////////////////////////
   // Priority pointer
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ptr_q <= '0;
      end else if (issue_o) begin
         // Search restarts one past the last winner
         ptr_q <= core_id_t'((int'(win) + 1) % NUM_CORES);
      end
   end

endmodule

/* rtl/int_mult_unit.sv */
// Pipelined integer multiplier
`timescale 1ns/1ps

module int_mult_unit #(
   parameter int MULT_STAGES = 2
) (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               issue_i,
   input  apu_pkg::mult_cmd_t cmd_i,
   input  apu_pkg::core_id_t  tag_i,
   output apu_pkg::unit_rsp_t rsp_o
);

   import apu_pkg::*;

   logic                       hss;
   logic signed [WORD_W:0]     a_ext;
   logic signed [WORD_W:0]     b_ext;
   logic signed [2*WORD_W+1:0] prod;
   word_t                      sel_word;

   logic [MULT_STAGES-1:0]     vld_q;
   core_id_t                   tag_q [MULT_STAGES];
   word_t                      res_q [MULT_STAGES];

   // Extra top bit is the sign for HSS and zero otherwise
   assign hss   = (cmd_i.op == MUL_HSS);
   assign a_ext = {hss & cmd_i.a[WORD_W-1], cmd_i.a};
   assign b_ext = {hss & cmd_i.b[WORD_W-1], cmd_i.b};
   assign prod  = a_ext * b_ext;

   always_comb begin
      case (cmd_i.op)
         MUL_HSS, MUL_HUU: sel_word = prod[2*WORD_W-1:WORD_W];
         default:          sel_word = prod[WORD_W-1:0];
      endcase
   end

   //////////////////////////////
   // Result shift chain
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vld_q <= '0;
      end else begin
         vld_q[0] <= issue_i;
         for (int s = 1; s < MULT_STAGES; s++) begin
            vld_q[s] <= vld_q[s-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      tag_q[0] <= tag_i;
      res_q[0] <= sel_word;
      for (int s = 1; s < MULT_STAGES; s++) begin
         tag_q[s] <= tag_q[s-1];
         res_q[s] <= res_q[s-1];
      end
   end

   assign rsp_o.valid  = vld_q[MULT_STAGES-1];
   assign rsp_o.tag    = tag_q[MULT_STAGES-1];
   assign rsp_o.result = res_q[MULT_STAGES-1];

endmodule

/* rtl/int_div_unit.sv */
// Iterative integer divider
`timescale 1ns/1ps

module int_div_unit (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               issue_i,
   input  apu_pkg::div_cmd_t  cmd_i,
   input  apu_pkg::core_id_t  tag_i,
   output logic               ready_o,
   output apu_pkg::unit_rsp_t rsp_o
);

   import apu_pkg::*;

   localparam int CNT_W = $clog2(WORD_W);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_FIX
   } state_e;

   state_e           state_q;
   logic [CNT_W-1:0] cnt_q;
   logic             vld_q;
   logic             start;

   // Operand capture
   logic             signed_op;
   logic             a_neg;
   logic             b_neg;
   word_t            a_mag;
   word_t            b_mag;

   div_op_e          op_q;
   core_id_t         tag_q;
   logic             neg_a_q;
   logic             neg_b_q;
   logic             b_zero_q;
   word_t            rem_q;
   word_t            quo_q;
   word_t            div_q;
   word_t            res_q;

   logic [WORD_W:0]   shifted;
   logic [WORD_W+1:0] diff;
   logic              fits;
   word_t             quo_fix;
   word_t             rem_fix;
   logic              is_rem;

   // Busy through the delivery cycle
   assign ready_o = (state_q == ST_IDLE) && !vld_q;
   assign start   = issue_i && ready_o;

   assign signed_op = (cmd_i.op == DIV_S) || (cmd_i.op == REM_S);
   assign a_neg     = signed_op && cmd_i.a[WORD_W-1];
   assign b_neg     = signed_op && cmd_i.b[WORD_W-1];
   assign a_mag     = a_neg ? -cmd_i.a : cmd_i.a;
   assign b_mag     = b_neg ? -cmd_i.b : cmd_i.b;

   //////////////////////////////
   // Restoring step
   //////////////////////////////

   assign shifted = {rem_q, quo_q[WORD_W-1]};
   assign diff    = {1'b0, shifted} - {2'b00, div_q};
   assign fits    = ~diff[WORD_W+1];

   // Sign restore, divide by zero forces an all ones quotient
   assign quo_fix = b_zero_q ? '1 : ((neg_a_q ^ neg_b_q) ? -quo_q : quo_q);
   assign rem_fix = neg_a_q ? -rem_q : rem_q;
   assign is_rem  = (op_q == REM_S) || (op_q == REM_U);

   //////////////////////////////
   // Control FSM
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
         vld_q   <= 1'b0;
      end else begin
         vld_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (start) begin
                  state_q <= ST_RUN;
                  cnt_q   <= '0;
               end
            end
            ST_RUN: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == CNT_W'(WORD_W-1)) begin
                  state_q <= ST_FIX;
               end
            end
            ST_FIX: begin
               state_q <= ST_IDLE;
               vld_q   <= 1'b1;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Datapath
   always_ff @(posedge clk_i) begin
      if (start) begin
         op_q     <= cmd_i.op;
         tag_q    <= tag_i;
         neg_a_q  <= a_neg;
         neg_b_q  <= b_neg;
         b_zero_q <= (cmd_i.b == '0);
         rem_q    <= '0;
         quo_q    <= a_mag;
         div_q    <= b_mag;
      end else if (state_q == ST_RUN) begin
         rem_q <= fits ? diff[WORD_W-1:0] : shifted[WORD_W-1:0];
         quo_q <= {quo_q[WORD_W-2:0], fits};
      end else if (state_q == ST_FIX) begin
         res_q <= is_rem ? rem_fix : quo_fix;
      end
   end

   assign rsp_o.valid  = vld_q;
   assign rsp_o.tag    = tag_q;
   assign rsp_o.result = res_q;

endmodule

/* rtl/result_router.sv */
// Result steering and ack merge
`timescale 1ns/1ps

module result_router (
   input  apu_pkg::unit_rsp_t             mult_rsp_i,
   input  apu_pkg::unit_rsp_t             div_rsp_i,
   input  logic [apu_pkg::NUM_CORES-1:0]  mult_ack_i,
   input  logic [apu_pkg::NUM_CORES-1:0]  div_ack_i,
   output logic [apu_pkg::NUM_CORES-1:0]  core_ack_o,
   output apu_pkg::core_rsp_t             core_rsp_o [apu_pkg::NUM_CORES]
);

   import apu_pkg::*;

   logic [NUM_CORES-1:0] mult_hit;
   logic [NUM_CORES-1:0] div_hit;

   // One arbiter per type, so at most one ack is set per core
   assign core_ack_o = mult_ack_i | div_ack_i;

   //////////////////////////////
   // Per-core result select
   //////////////////////////////

   for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
      assign mult_hit[i] = mult_rsp_i.valid && (mult_rsp_i.tag == core_id_t'(i));
      assign div_hit[i]  = div_rsp_i.valid && (div_rsp_i.tag == core_id_t'(i));

      assign core_rsp_o[i].valid = mult_hit[i] || div_hit[i];

      // Multiplier first, though both cannot target one core together
      always_comb begin
         if (mult_hit[i]) begin
            core_rsp_o[i].result = mult_rsp_i.result;
         end else if (div_hit[i]) begin
            core_rsp_o[i].result = div_rsp_i.result;
         end else begin
            core_rsp_o[i].result = '0;
         end
      end
   end

endmodule

/* rtl/apu_cluster.sv */
// Shared arithmetic cluster top
`timescale 1ns/1ps

module apu_cluster #(
   parameter int MULT_STAGES = 2
) (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  apu_pkg::core_req_t             core_req_i [apu_pkg::NUM_CORES],
   output logic [apu_pkg::NUM_CORES-1:0]  core_ack_o,
   output apu_pkg::core_rsp_t             core_rsp_o [apu_pkg::NUM_CORES]
);

   import apu_pkg::*;

   logic [NUM_CORES-1:0] mult_req;
   logic [NUM_CORES-1:0] div_req;
   logic [NUM_CORES-1:0] mult_ack;
   logic [NUM_CORES-1:0] div_ack;
   mult_cmd_t            mult_pay [NUM_CORES];
   div_cmd_t             div_pay  [NUM_CORES];

   logic                 mult_issue;
   mult_cmd_t            mult_cmd;
   core_id_t             mult_tag;
   unit_rsp_t            mult_rsp;

   logic                 div_issue;
   logic                 div_ready;
   div_cmd_t             div_cmd;
   core_id_t             div_tag;
   unit_rsp_t            div_rsp;

   //////////////////////////////
   // Split requests by type
   //////////////////////////////

   for (genvar i = 0; i < NUM_CORES; i++) begin : g_split
      assign mult_req[i] = core_req_i[i].req && (core_req_i[i].apu_type == APU_MULT);
      assign div_req[i]  = core_req_i[i].req && (core_req_i[i].apu_type == APU_DIV);

      // Same operands, op reinterpreted for each unit
      assign mult_pay[i] = '{op: mult_op_e'(core_req_i[i].op),
                             a:  core_req_i[i].a,
                             b:  core_req_i[i].b};
      assign div_pay[i]  = '{op: div_op_e'(core_req_i[i].op),
                             a:  core_req_i[i].a,
                             b:  core_req_i[i].b};
   end

   //////////////////////////////
   // Multiplier path
   //////////////////////////////

   // Multiplier takes one item per cycle, so it is always ready
   apu_arbiter #(.payload_t(mult_cmd_t)) u_mult_arb (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (mult_req),
      .payload_i (mult_pay),
      .ready_i   (1'b1),
      .ack_o     (mult_ack),
      .issue_o   (mult_issue),
      .payload_o (mult_cmd),
      .tag_o     (mult_tag)
   );

   int_mult_unit #(.MULT_STAGES(MULT_STAGES)) u_mult (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .issue_i (mult_issue),
      .cmd_i   (mult_cmd),
      .tag_i   (mult_tag),
      .rsp_o   (mult_rsp)
   );

   //////////////////////////////
   // Divider path
   //////////////////////////////

   apu_arbiter #(.payload_t(div_cmd_t)) u_div_arb (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (div_req),
      .payload_i (div_pay),
      .ready_i   (div_ready),
      .ack_o     (div_ack),
      .issue_o   (div_issue),
      .payload_o (div_cmd),
      .tag_o     (div_tag)
   );

   int_div_unit u_div (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .issue_i (div_issue),
      .cmd_i   (div_cmd),
      .tag_i   (div_tag),
      .ready_o (div_ready),
      .rsp_o   (div_rsp)
   );

   // Results and acks back to the cores
   result_router u_router (
      .mult_rsp_i (mult_rsp),
      .div_rsp_i  (div_rsp),
      .mult_ack_i (mult_ack),
      .div_ack_i  (div_ack),
      .core_ack_o (core_ack_o),
      .core_rsp_o (core_rsp_o)
   );

endmodule

/* verif/apu_cluster_asserts.sv */
// Arbiter protocol assertions
`timescale 1ns/1ps

module apu_arbiter_asserts (
   input logic                          clk_i,
   input logic                          rst_i,
   input logic [apu_pkg::NUM_CORES-1:0] req_i,
   input logic                          ready_i,
   input logic [apu_pkg::NUM_CORES-1:0] ack_i,
   input logic                          issue_i
);

   import apu_pkg::*;

   // Count of assertion failures
   int unsigned          fail_cnt = 0;
   logic [NUM_CORES-1:0] stray_ack;

   assign stray_ack = ack_i & ~req_i;

   a_one_ack: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(ack_i))
      else begin
         $error("arbiter acknowledged more than one core in a cycle");
         fail_cnt++;
      end

   a_ack_req: assert property (@(posedge clk_i) disable iff (rst_i) stray_ack == '0)
      else begin
         $error("arbiter acknowledged a core that was not requesting");
         fail_cnt++;
      end

   // Unit busy means no issue
   a_issue_ready: assert property (@(posedge clk_i) disable iff (rst_i) !ready_i |-> !issue_i)
      else begin
         $error("arbiter issued while the unit was not ready");
         fail_cnt++;
      end

endmodule

bind apu_arbiter apu_arbiter_asserts u_chk (
   .clk_i   (clk_i),
   .rst_i   (rst_i),
   .req_i   (req_i),
   .ready_i (ready_i),
   .ack_i   (ack_o),
   .issue_i (issue_o)
);

/* verif/tb_apu_cluster.sv */
// APU cluster testbench
`timescale 1ns/1ps

module tb_apu_cluster;

   import apu_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 5;
   localparam int MULT_STAGES  = 2;
   localparam int SEED         = 92768;
   localparam int ROUNDS       = 40;
   // Divide issue to next divide issue including the ready gap
   localparam int DIV_CYCLES   = 36;
   // A core can queue behind the three others on the divider
   localparam int WAIT_LIMIT   = NUM_CORES * DIV_CYCLES + 16;
   // Worst case has every request queued on the divider one at a time
   localparam int TIMEOUT_CYCLES = (ROUNDS * NUM_CORES + 20) * DIV_CYCLES;

   logic                 clk_i;
   logic                 rst_i;
   core_req_t            core_req [NUM_CORES];
   logic [NUM_CORES-1:0] core_ack;
   core_rsp_t            core_rsp [NUM_CORES];

   int       cycle_cnt    = 0;
   int       test_errs    = 0;
   int       tests_passed = 0;
   int       tests_failed = 0;
   core_id_t grant_q [$];

   apu_cluster #(.MULT_STAGES(MULT_STAGES)) uut (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .core_req_i (core_req),
      .core_ack_o (core_ack),
      .core_rsp_o (core_rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Run stopped after %0d cycles, the tests did not finish", cycle_cnt);
         $display("Result: FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Reference models
   //////////////////////////////

   function automatic word_t mult_model(input mult_op_e op_code, input word_t a, input word_t b);
      logic [63:0]        up;
      logic signed [63:0] sp;
      word_t              res;
      up = {32'b0, a} * {32'b0, b};
      sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      case (op_code)
         MUL_HSS: res = sp[63:32];
         MUL_HUU: res = up[63:32];
         default: res = up[31:0];
      endcase
      return res;
   endfunction

   function automatic word_t div_model(input div_op_e op_code, input word_t a, input word_t b);
      logic signed [31:0] sa;
      logic signed [31:0] sb;
      word_t              q;
      word_t              r;
      sa = a;
      sb = b;
      if (b == '0) begin
         q = '1;
         r = a;
      end else if (op_code == DIV_U || op_code == REM_U) begin
         q = a / b;
         r = a % b;
      end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
         // Signed overflow case
         q = 32'h8000_0000;
         r = '0;
      end else begin
         q = sa / sb;
         r = sa % sb;
      end
      return (op_code == REM_S || op_code == REM_U) ? r : q;
   endfunction

   //////////////////////////////
   // Compare and bookkeeping
   //////////////////////////////

   task automatic check_result(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
         test_errs++;
      end
   endtask

   task automatic check_core(input string name, input core_id_t expected,
                             input core_id_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected core %0d, actual core %0d", name, expected, actual);
         test_errs++;
      end
   endtask

   task automatic finish_test(input string name);
      if (test_errs == 0) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      rst_i <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_i <= 1'b0;
   endtask

   // One request from one core through ack and result
   task automatic issue_and_check(input string name, input int c, input apu_type_e kind,
                                  input logic [1:0] op_code, input word_t a, input word_t b,
                                  output int ack_cyc, output int rsp_cyc);
      core_req_t rq;
      word_t     expected;
      int        waited;
      rq       = '{req: 1'b1, apu_type: kind, op: op_code, a: a, b: b};
      expected = (kind == APU_MULT) ? mult_model(mult_op_e'(op_code), a, b)
                                    : div_model(div_op_e'(op_code), a, b);
      ack_cyc  = -1;
      rsp_cyc  = -1;
      @(posedge clk_i);
      core_req[c] <= rq;
      waited = 0;
      @(negedge clk_i);
      while (!core_ack[c] && waited < WAIT_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!core_ack[c]) begin
         $display("%s: core %0d was never acknowledged", name, c);
         test_errs++;
         @(posedge clk_i);
         core_req[c] <= '0;
         return;
      end
      ack_cyc = cycle_cnt;
      grant_q.push_back(core_id_t'(c));
      @(posedge clk_i);
      core_req[c] <= '0;
      waited = 0;
      @(negedge clk_i);
      while (!core_rsp[c].valid && waited < WAIT_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!core_rsp[c].valid) begin
         $display("%s: core %0d never received its result", name, c);
         test_errs++;
         return;
      end
      rsp_cyc = cycle_cnt;
      check_result(name, expected, core_rsp[c].result);
      if (kind == APU_MULT && rsp_cyc - ack_cyc != MULT_STAGES) begin
         $display("%s: multiply result came %0d cycles after the acknowledge, not %0d",
                  name, rsp_cyc - ack_cyc, MULT_STAGES);
         test_errs++;
      end
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic test_mult_ops();
      int ac;
      int rc;
      issue_and_check("lo ones", 0, APU_MULT, MUL_LO, 32'hffff_ffff, 32'hffff_ffff, ac, rc);
      issue_and_check("lo mixed", 0, APU_MULT, MUL_LO, 32'h8000_0001, 32'h0000_0003, ac, rc);
      issue_and_check("hss ones", 0, APU_MULT, MUL_HSS, 32'hffff_ffff, 32'hffff_ffff, ac, rc);
      issue_and_check("hss min", 0, APU_MULT, MUL_HSS, 32'h8000_0000, 32'h8000_0000, ac, rc);
      issue_and_check("hss neg", 0, APU_MULT, MUL_HSS, 32'hffff_fffe, 32'h7fff_ffff, ac, rc);
      issue_and_check("huu ones", 0, APU_MULT, MUL_HUU, 32'hffff_ffff, 32'hffff_ffff, ac, rc);
      issue_and_check("huu mixed", 0, APU_MULT, MUL_HUU, 32'h8000_0000, 32'hdead_beef, ac, rc);
      finish_test("multiply operations");
   endtask

   task automatic test_div_ops();
      int ac;
      int rc;
      issue_and_check("div_s neg", 1, APU_DIV, DIV_S, 32'hffff_fff9, 32'd2, ac, rc);
      issue_and_check("rem_s neg", 1, APU_DIV, REM_S, 32'hffff_fff9, 32'd2, ac, rc);
      issue_and_check("div_s mixed", 1, APU_DIV, DIV_S, 32'd7, 32'hffff_fffe, ac, rc);
      issue_and_check("rem_s mixed", 1, APU_DIV, REM_S, 32'd7, 32'hffff_fffe, ac, rc);
      issue_and_check("div_u big", 1, APU_DIV, DIV_U, 32'hffff_fff9, 32'd2, ac, rc);
      issue_and_check("rem_u big", 1, APU_DIV, REM_U, 32'hffff_fff9, 32'd10, ac, rc);
      issue_and_check("div_s zero", 1, APU_DIV, DIV_S, 32'hffff_fffb, 32'd0, ac, rc);
      issue_and_check("rem_s zero", 1, APU_DIV, REM_S, 32'hffff_fff9, 32'd0, ac, rc);
      issue_and_check("rem_u zero", 1, APU_DIV, REM_U, 32'd123, 32'd0, ac, rc);
      issue_and_check("div_s ovf", 1, APU_DIV, DIV_S, 32'h8000_0000, 32'hffff_ffff, ac, rc);
      issue_and_check("rem_s ovf", 1, APU_DIV, REM_S, 32'h8000_0000, 32'hffff_ffff, ac, rc);
      finish_test("divide operations");
   endtask

   // All four cores hit the multiplier in one cycle
   task automatic test_contention();
      int ac [NUM_CORES];
      int rc [NUM_CORES];
      apply_reset();
      grant_q.delete();
      fork
         issue_and_check("race 0", 0, APU_MULT, MUL_LO, 32'd1000, 32'd3, ac[0], rc[0]);
         issue_and_check("race 1", 1, APU_MULT, MUL_HSS, 32'hffff_0000, 32'd7, ac[1], rc[1]);
         issue_and_check("race 2", 2, APU_MULT, MUL_HUU, 32'hffff_0000, 32'd7, ac[2], rc[2]);
         issue_and_check("race 3", 3, APU_MULT, MUL_LO, 32'h1234_5678, 32'd16, ac[3], rc[3]);
      join
      if (grant_q.size() != NUM_CORES) begin
         $display("contention: %0d grants seen instead of %0d", grant_q.size(), NUM_CORES);
         test_errs++;
      end else begin
         for (int k = 0; k < NUM_CORES; k++) begin
            check_core("contention order", core_id_t'(k), grant_q[k]);
            if (ac[k] != ac[0] + k) begin
               $display("contention: core %0d acknowledged in cycle %0d, not one per cycle",
                        k, ac[k]);
               test_errs++;
            end
         end
      end
      finish_test("contention order");
   endtask

   task automatic test_backpressure();
      int ac2;
      int rc2;
      int ac3;
      int rc3;
      fork
         issue_and_check("busy core 2", 2, APU_DIV, DIV_S, 32'hffff_ff9c, 32'd7, ac2, rc2);
         issue_and_check("busy core 3", 3, APU_DIV, REM_U, 32'd1000, 32'd33, ac3, rc3);
      join
      if (ac2 >= 0 && ac3 >= 0 && ac3 <= rc2) begin
         $display("back-pressure: core 3 was acknowledged before core 2 got its result");
         test_errs++;
      end
      finish_test("divider back-pressure");
   endtask

   task automatic core_traffic(input int c);
      apu_type_e  kind;
      logic [1:0] op_code;
      word_t      a;
      word_t      b;
      int         ac;
      int         rc;
      for (int r = 0; r < ROUNDS; r++) begin
         kind    = ($urandom_range(1, 0) == 0) ? APU_MULT : APU_DIV;
         op_code = (kind == APU_MULT) ? 2'($urandom_range(2, 0)) : 2'($urandom_range(3, 0));
         a       = $urandom();
         // Small divisors now and then including zero
         b       = ($urandom_range(3, 0) == 0) ? word_t'($urandom_range(15, 0)) : $urandom();
         issue_and_check($sformatf("random core %0d", c), c, kind, op_code, a, b, ac, rc);
      end
   endtask

   task automatic test_random_traffic();
      fork
         core_traffic(0);
         core_traffic(1);
         core_traffic(2);
         core_traffic(3);
      join
      finish_test("mixed random traffic");
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      int assert_fails;
      void'($urandom(SEED));
      rst_i <= 1'b1;
      for (int i = 0; i < NUM_CORES; i++) begin
         core_req[i] <= '0;
      end
      apply_reset();
      test_mult_ops();
      test_div_ops();
      test_contention();
      test_backpressure();
      test_random_traffic();
      assert_fails = int'(uut.u_mult_arb.u_chk.fail_cnt + uut.u_div_arb.u_chk.fail_cnt);
      $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
               tests_passed, tests_failed, assert_fails);
      if (tests_failed == 0 && assert_fails == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* sim.f */
rtl/apu_pkg.sv
rtl/apu_arbiter.sv
rtl/int_mult_unit.sv
rtl/int_div_unit.sv
rtl/result_router.sv
rtl/apu_cluster.sv
verif/apu_cluster_asserts.sv
verif/tb_apu_cluster.sv

/* Makefile */
TOP := tb_apu_cluster
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
